/* flist.f */
+incdir+source
source/adc_acq_pkg.sv
source/acq_status_if.sv
source/adc_input_reg.sv
source/adc_to_circ_buf.sv
source/circ_buf_ram.sv
source/acq_trig_ctrl.sv
source/cbuf_readout.sv
source/adc_acq_top.sv
sim/adc_acq_assert.sv
sim/adc_acq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass is read from the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module adc_acq_tb -f flist.f && \
    ./obj_dir/Vadc_acq_tb +verilator+error+limit+100 | tee /dev/stderr | \
    grep -qx "PASS: all tests" && \
    echo "run_sim: passed" || { echo "run_sim: failed"; exit 1; }

/* sim/adc_acq_assert.sv */
`include "adc_acq_params.svh"
`default_nettype none

module adc_acq_assert (
    input wire                      adc_clk,
    input wire                      reset,
    input wire                      rd_req,
    input wire                      rd_ack,
    input wire [2*`SAMPLE_W+1:0]    rd_data,
    input wire                      acq_busy,
    input wire                      acq_done
);

    int fail_cnt = 0; // failed assertions so far, watched by the testbench

    //////////////////////////////
    // host handshake
    //////////////////////////////

    // ack only ever answers a pending request, the host may drop req once ack is seen
    ack_needs_req: assert property (@(posedge adc_clk) disable iff (reset)
        $rose(rd_ack) |-> $past(rd_req))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_ack rose while rd_req was low");
        end

    // word held for the whole time ack is up
    data_held: assert property (@(posedge adc_clk) disable iff (reset)
        (rd_ack && $past(rd_ack)) |-> $stable(rd_data))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rd_data changed while rd_ack was high");
        end

    //////////////////////////////
    // controller
    //////////////////////////////

    // done only follows the busy phase and never overlaps it
    done_after_busy: assert property (@(posedge adc_clk) disable iff (reset)
        acq_done |-> (!acq_busy && ($past(acq_busy) || $past(acq_done))))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("acq_done high together with acq_busy or without a busy phase");
        end

endmodule

bind adc_acq_top adc_acq_assert i_adc_acq_assert (
    .adc_clk  (adc_clk),
    .reset    (reset),
    .rd_req   (rd_req),
    .rd_ack   (rd_ack),
    .rd_data  (rd_data),
    .acq_busy (acq_busy),
    .acq_done (acq_done)
);

`default_nettype wire

/* sim/adc_acq_tb.sv */
`include "adc_acq_params.svh"
`default_nettype none

module adc_acq_tb;

    localparam int sw         = `SAMPLE_W;
    localparam int ww         = 2 * sw + 2;        // sample-pair word width
    localparam int depth      = 1 << `CBUF_ADDR_W;
    localparam int post_len   = `POST_TRIG_LEN;
    localparam int wrap_wait  = depth + 44;        // long pre-trigger, buffer wraps
    localparam int short_wait = 20;                // early trigger, no wrap
    localparam int n_acq      = 6;
    localparam int max_cycles = n_acq * (depth + post_len + wrap_wait + 6 * depth) + 50;

    logic          adc_clk = 1'b0;
    logic          reset;
    logic [sw:0]   adc_lane0;
    logic [sw:0]   adc_lane1;
    logic          use_dummy_data;
    logic          dummy_dat_reset_mode;
    logic          arm;
    logic          trig_in;
    logic          rd_req;
    logic          acq_busy;
    logic          acq_done;
    logic          ovr_seen;
    logic          rd_ack;
    logic [ww-1:0] rd_data;
    logic          rd_trig;
    logic          rd_last;

    logic [ww-1:0] hist [$];    // {lane1, lane0} for each cycle of the acquisition
    int            pre_wait;    // cycles between arm and trigger
    bit            expect_wrap;
    int            expect_ovr;  // over-range words expected in the readout
    bit            start_read;
    bit            read_done;
    int            cycles = 0;

    adc_acq_top i_adc_acq_top (
        .adc_clk              (adc_clk),
        .reset                (reset),
        .adc_lane0            (adc_lane0),
        .adc_lane1            (adc_lane1),
        .use_dummy_data       (use_dummy_data),
        .dummy_dat_reset_mode (dummy_dat_reset_mode),
        .arm                  (arm),
        .trig_in              (trig_in),
        .rd_req               (rd_req),
        .acq_busy             (acq_busy),
        .acq_done             (acq_done),
        .ovr_seen             (ovr_seen),
        .rd_ack               (rd_ack),
        .rd_data              (rd_data),
        .rd_trig              (rd_trig),
        .rd_last              (rd_last)
    );

    initial begin
        forever #20 adc_clk = ~adc_clk;
    end

    //////////////////////////////
    // reference and checks
    //////////////////////////////

    // word layout from bit 0 up: ovr0, samp0, ovr1, samp1
    function automatic logic [ww-1:0] expected_word(input bit dummy, input logic [ww-1:0] pair,
                                                    input logic [sw-1:0] cnt);
        logic [sw:0] l0;
        logic [sw:0] l1;
        l0 = pair[sw:0];
        l1 = pair[ww-1:sw+1];
        if (dummy) begin
            return {~cnt, 1'b0, cnt, 1'b0}; // counter and its inverse, no clipping
        end
        return {l1[sw-1:0], l1[sw], l0[sw-1:0], l0[sw]};
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge adc_clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", cycles);
            abort_run();
        end
    end

    always @(negedge adc_clk) begin
        if (i_adc_acq_top.i_adc_acq_assert.fail_cnt != 0) begin
            $display("a bound assertion failed, see the error above");
            abort_run();
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one cycle of random lanes, called and returning at a falling edge
    task automatic step(input bit ovr);
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $urandom;
        r1 = $urandom;
        adc_lane0 = {ovr, r0[sw-1:0]};
        adc_lane1 = {1'b0, r1[sw-1:0]};
        if (arm || acq_busy) begin
            hist.push_back({adc_lane1, adc_lane0}); // arm cycle lands at address 0
        end
        @(negedge adc_clk);
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        repeat (4) step(1'b0);
        reset = 1'b0;
    endtask

    task automatic run_acq(input bit dummy, input bit rst_mode, input int wait_cyc,
                           input int ovr_at, input bit wrap_exp);
        use_dummy_data       = dummy;
        dummy_dat_reset_mode = rst_mode;
        pre_wait             = wait_cyc;
        expect_wrap          = wrap_exp;
        expect_ovr           = (ovr_at >= 0) ? 1 : 0;
        hist.delete();
        arm = 1'b1;
        step(1'b0);
        arm = 1'b0;
        check_equal("ovr_seen", ovr_seen, 0);         // cleared by arm
        check_equal("acq_busy", acq_busy, 1);         // armed, buffer filling
        for (int i = 0; i < wait_cyc; i++) begin
            step(i == ovr_at);
        end
        check_equal("ovr_seen", ovr_seen, expect_ovr);
        trig_in = 1'b1;
        step(1'b0);
        trig_in = 1'b0;
        while (!acq_done) step(1'b0);                 // post-trigger tail
        read_done  = 1'b0;
        start_read = 1'b1;
        while (!read_done) step(1'b0);
        start_read = 1'b0;
        step(1'b0);
        step(1'b0);
        check_equal("acq_done", acq_done, 0);         // release from the readout
        check_equal("acq_busy", acq_busy, 0);         // back in idle, not re-armed
    endtask

    initial begin : stimulus
        void'($urandom(32'he9d0_6d3b));
        reset                = 1'b1;
        adc_lane0            = '0;
        adc_lane1            = '0;
        use_dummy_data       = 1'b0;
        dummy_dat_reset_mode = 1'b0;
        arm                  = 1'b0;
        trig_in              = 1'b0;
        rd_req               = 1'b0;
        start_read           = 1'b0;
        read_done            = 1'b0;
        repeat (4) @(negedge adc_clk);
        reset = 1'b0;
        run_acq(1'b0, 1'b0, wrap_wait, -1, 1'b1);     // adc, wrapped
        run_acq(1'b0, 1'b0, short_wait, -1, 1'b0);    // adc, partial fill
        run_acq(1'b1, 1'b0, wrap_wait, -1, 1'b1);     // dummy counter, free running
        reset_dut();                                  // counter back to 0
        run_acq(1'b1, 1'b1, short_wait, -1, 1'b0);    // dummy, restart on trigger
        run_acq(1'b0, 1'b0, short_wait, 7, 1'b0);     // single clipped sample
        run_acq(1'b0, 1'b0, wrap_wait, -1, 1'b1);     // re-arm with fresh data
        $display("PASS: all tests");
        $finish;
    end

    //////////////////////////////
    // readout and compare
    //////////////////////////////

    task automatic read_buffer();
        logic [ww-1:0] words [$];
        logic [ww-1:0] exp;
        int            trig_idx;
        int            start;
        int            n_ovr;
        bit            got_last;
        trig_idx = -1;
        start    = -1;
        n_ovr    = 0;
        got_last = 1'b0;
        while (!got_last) begin
            rd_req = 1'b1;
            @(negedge adc_clk);
            while (!rd_ack) @(negedge adc_clk);       // address cycle plus ram read
            words.push_back(rd_data);
            got_last = rd_last;
            if (rd_trig) begin
                if (trig_idx >= 0) begin
                    $display("second word flagged rd_trig at index %0d", words.size() - 1);
                    abort_run();
                end
                trig_idx = words.size() - 1;
            end
            if (words.size() > depth) begin
                $display("readout returned more words than the buffer holds");
                abort_run();
            end
            rd_req = 1'b0;
            @(negedge adc_clk);
            while (rd_ack) @(negedge adc_clk);
        end
        if (expect_wrap) begin
            check_equal("word count", words.size(), depth);
        end else begin
            check_equal("word count below depth", words.size() < depth, 1);
        end
        if (trig_idx < 0) begin
            $display("no word of the acquisition was flagged rd_trig");
            abort_run();
        end
        check_equal("words after rd_trig", words.size() - 1 - trig_idx, post_len);
        if (use_dummy_data) begin
            for (int i = 0; i < words.size(); i++) begin
                if (i == 0) begin
                    exp = expected_word(1'b1, '0, words[0][sw:1]);
                end else if (dummy_dat_reset_mode && (i == trig_idx + 1)) begin
                    exp = expected_word(1'b1, '0, '0);  // counter cleared by the trigger
                end else begin
                    exp = expected_word(1'b1, '0, words[i-1][sw:1] + 1'b1);
                end
                check_equal($sformatf("rd_data[%0d]", i), words[i], exp);
            end
            if (dummy_dat_reset_mode) begin
                check_equal("rd_trig count within pre-trigger wait",
                            words[trig_idx][sw:1] <= pre_wait, 1);
            end
        end else begin
            if (!expect_wrap) begin
                start = 0;                            // first pair after arm
            end
            for (int j = 0; (j < hist.size()) && expect_wrap && (start < 0); j++) begin
                if (expected_word(1'b0, hist[j], '0) == words[0]) begin
                    start = j;
                end
            end
            if (start < 0) begin
                $display("first word read matches no recorded lane pair");
                abort_run();
            end
            for (int i = 0; i < words.size(); i++) begin
                if (start + i >= hist.size()) begin
                    $display("readout runs past the recorded lane pairs");
                    abort_run();
                end
                exp = expected_word(1'b0, hist[start+i], '0);
                check_equal($sformatf("rd_data[%0d]", i), words[i], exp);
                if (words[i][0] || words[i][sw+1]) begin
                    n_ovr++;
                end
            end
            check_equal("over-range words", n_ovr, expect_ovr);
        end
    endtask

    initial begin : compare
        forever begin
            @(negedge adc_clk);
            if (start_read && !read_done) begin
                read_buffer();
                read_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/acq_status_if.sv */
`include "adc_acq_params.svh"
`default_nettype none

// end-of-acquisition status, controller to readout
interface acq_status_if;

    logic                    acq_done;    // buffer frozen, contents valid
    logic [`CBUF_ADDR_W-1:0] trig_addr;   // where the trigger word landed
    logic [`CBUF_ADDR_W-1:0] last_addr;   // newest word in the buffer
    logic                    wrapped;     // write pointer passed the top at least once
    logic                    acq_release; // one-cycle pulse, readout finished

    // controller side
    modport ctrl (
        output acq_done,
        output trig_addr,
        output last_addr,
        output wrapped,
        input  acq_release
    );

    // readout side
    modport rdout (
        input  acq_done,
        input  trig_addr,
        input  last_addr,
        input  wrapped,
        output acq_release
    );

endinterface

`default_nettype wire

/* source/acq_trig_ctrl.sv */
`include "adc_acq_params.svh"
`default_nettype none

module acq_trig_ctrl
    import adc_acq_pkg::*;
(
    input  wire                       adc_clk,
    input  wire                       reset,
    input  wire                       arm,        // start a new acquisition
    input  wire                       trig_in,    // external trigger, level sampled
    input  wire                       wr_valid,   // a write lands this cycle
    input  wire [`CBUF_ADDR_W-1:0]    wr_addr,
    output logic                      cbuf_wr_en,
    output logic                      trig_pulse,
    output logic                      acq_busy,
    acq_status_if.ctrl                status
);

    localparam logic [`CBUF_ADDR_W-1:0] post_len = `POST_TRIG_LEN;
    localparam logic [`CBUF_ADDR_W-1:0] top_addr = '1;

    acq_state_t              state;
    logic [`CBUF_ADDR_W-1:0] post_cnt; // enabled cycles left after the trigger

    //////////////////////////////
    // decoded outputs
    //////////////////////////////

    assign trig_pulse      = (state == st_armed) && trig_in; // only the first trigger counts
    assign acq_busy        = (state == st_armed) || (state == st_post_trig);
    assign status.acq_done = (state == st_done);

    //////////////////////////////
    // acquisition fsm
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            state          <= st_idle;
            cbuf_wr_en     <= 1'b0;
            post_cnt       <= '0;
            status.wrapped <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (arm) begin
                        state          <= st_armed;
                        cbuf_wr_en     <= 1'b1;   // buffer starts filling
                        status.wrapped <= 1'b0;
                    end
                end
                st_armed: begin
                    if (trig_in) begin
                        state    <= st_post_trig;
                        post_cnt <= post_len;
                    end
                end
                st_post_trig: begin
                    // writes trail the enable by one cycle, so the enable
                    // covers the trigger word plus post_len more
                    if (cbuf_wr_en) begin
                        post_cnt <= post_cnt - 1'b1;
                        if (post_cnt == 'd1) begin
                            cbuf_wr_en <= 1'b0;
                        end
                    end else if (wr_valid) begin
                        state <= st_done;         // final write landing now
                    end
                end
                st_done: begin
                    if (status.acq_release) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
            if (wr_valid && (wr_addr == top_addr)) begin
                status.wrapped <= 1'b1;           // oldest data now follows last_addr
            end
        end
    end

    //////////////////////////////
    // address capture
    //////////////////////////////

    // both fields freeze in done because no writes happen there
    always_ff @(posedge adc_clk) begin
        if (wr_valid && (state == st_post_trig) && (post_cnt == post_len)) begin
            status.trig_addr <= wr_addr;          // first write after the trigger
        end
        if (wr_valid) begin
            status.last_addr <= wr_addr;
        end
    end

endmodule

`default_nettype wire

/* source/adc_acq_params.svh */
`ifndef ADC_ACQ_PARAMS_SVH
`define ADC_ACQ_PARAMS_SVH

//////////////////////////////
// buffer geometry
//////////////////////////////

// write/read address width, 2**8 = 256 sample-pair words
`define CBUF_ADDR_W 8

// words written after the trigger word, must stay below the depth
`define POST_TRIG_LEN 100

//////////////////////////////
// adc format
//////////////////////////////

`define SAMPLE_W 12 // bits per adc sample, over-range bit not included

`endif

/* source/adc_acq_pkg.sv */
`include "adc_acq_params.svh"
`default_nettype none

package adc_acq_pkg;

    //////////////////////////////
    // acquisition controller
    //////////////////////////////

    // idle      waiting for arm, buffer writes off
    // armed     pre-trigger fill, buffer runs circular
    // post_trig trigger accepted, counting the tail
    // done      frozen, waiting for the readout to release
    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_armed     = 2'd1,
        st_post_trig = 2'd2,
        st_done      = 2'd3
    } acq_state_t;

    //////////////////////////////
    // sample-pair word
    //////////////////////////////

    // packed msb first, so bit 0 ends up as the first over-range bit
    typedef struct packed {
        logic [`SAMPLE_W-1:0] samp1; // second sample, bits 25:14
        logic                 ovr1;  // second over-range, bit 13
        logic [`SAMPLE_W-1:0] samp0; // first sample, bits 12:1
        logic                 ovr0;  // first over-range, bit 0
    } sample_pair_t;

endpackage

`default_nettype wire

/* source/adc_acq_top.sv */
`include "adc_acq_params.svh"
`default_nettype none

module adc_acq_top
    import adc_acq_pkg::*;
(
    input  wire                     adc_clk,
    input  wire                     reset,
    input  wire [`SAMPLE_W:0]       adc_lane0,
    input  wire [`SAMPLE_W:0]       adc_lane1,
    input  wire                     use_dummy_data,
    input  wire                     dummy_dat_reset_mode,
    input  wire                     arm,
    input  wire                     trig_in,
    input  wire                     rd_req,
    output logic                    acq_busy,
    output logic                    acq_done,
    output logic                    ovr_seen,
    output logic                    rd_ack,
    output logic [2*`SAMPLE_W+1:0]  rd_data,
    output logic                    rd_trig,
    output logic                    rd_last
);

    //////////////////////////////
    // internal nets
    //////////////////////////////

    sample_pair_t            pair_dat;
    sample_pair_t            wr_dat;
    sample_pair_t            rd_q;
    logic                    cbuf_wr_en;
    logic                    trig_pulse;
    logic                    wr_valid;
    logic [`CBUF_ADDR_W-1:0] wr_addr;
    logic [`CBUF_ADDR_W-1:0] rd_addr;

    acq_status_if i_status ();

    assign acq_done = i_status.acq_done; // host sees the frozen flag directly

    //////////////////////////////
    // write path
    //////////////////////////////

    adc_input_reg i_adc_input_reg (
        .adc_clk   (adc_clk),
        .reset     (reset),
        .adc_lane0 (adc_lane0),
        .adc_lane1 (adc_lane1),
        .arm       (arm),
        .pair_dat  (pair_dat),
        .ovr_seen  (ovr_seen)
    );

    adc_to_circ_buf i_adc_to_circ_buf (
        .adc_clk              (adc_clk),
        .reset                (reset),
        .pair_dat             (pair_dat),
        .use_dummy_data       (use_dummy_data),
        .dummy_dat_reset_mode (dummy_dat_reset_mode),
        .cbuf_wr_en           (cbuf_wr_en),
        .trig_pulse           (trig_pulse),
        .wr_valid             (wr_valid),
        .wr_addr              (wr_addr),
        .wr_dat               (wr_dat)
    );

    circ_buf_ram i_circ_buf_ram (
        .adc_clk  (adc_clk),
        .wr_valid (wr_valid),
        .wr_addr  (wr_addr),
        .wr_dat   (wr_dat),
        .rd_addr  (rd_addr),
        .rd_q     (rd_q)
    );

    //////////////////////////////
    // control and readout
    //////////////////////////////

    acq_trig_ctrl i_acq_trig_ctrl (
        .adc_clk    (adc_clk),
        .reset      (reset),
        .arm        (arm),
        .trig_in    (trig_in),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .cbuf_wr_en (cbuf_wr_en),
        .trig_pulse (trig_pulse),
        .acq_busy   (acq_busy),
        .status     (i_status)
    );

    cbuf_readout i_cbuf_readout (
        .adc_clk (adc_clk),
        .reset   (reset),
        .rd_req  (rd_req),
        .rd_q    (rd_q),
        .rd_addr (rd_addr),
        .rd_ack  (rd_ack),
        .rd_data (rd_data),
        .rd_trig (rd_trig),
        .rd_last (rd_last),
        .status  (i_status)
    );

endmodule

`default_nettype wire

/* source/adc_input_reg.sv */
`include "adc_acq_params.svh"
`default_nettype none

module adc_input_reg
    import adc_acq_pkg::*;
(
    input  wire                 adc_clk,
    input  wire                 reset,
    input  wire [`SAMPLE_W:0]   adc_lane0,  // {ovr, sample}, first sample of the pair
    input  wire [`SAMPLE_W:0]   adc_lane1,  // {ovr, sample}, second sample of the pair
    input  wire                 arm,        // new acquisition, clears the sticky flag
    output sample_pair_t        pair_dat,
    output logic                ovr_seen    // some sample clipped since the last arm
);

    logic lane_ovr; // either lane over range this cycle

    assign lane_ovr = adc_lane0[`SAMPLE_W] | adc_lane1[`SAMPLE_W];

    //////////////////////////////
    // lane capture
    //////////////////////////////

    // plain pipeline register, repacks the lanes into the pair layout
    always_ff @(posedge adc_clk) begin
        pair_dat.ovr0  <= adc_lane0[`SAMPLE_W];
        pair_dat.samp0 <= adc_lane0[`SAMPLE_W-1:0];
        pair_dat.ovr1  <= adc_lane1[`SAMPLE_W];
        pair_dat.samp1 <= adc_lane1[`SAMPLE_W-1:0];
    end

    //////////////////////////////
    // sticky over-range
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (reset || arm) begin
            ovr_seen <= 1'b0;          // arm wins over a same-cycle clip
        end else if (lane_ovr) begin
            ovr_seen <= 1'b1;          // hold until the next arm
        end
    end

endmodule

`default_nettype wire

/* source/adc_to_circ_buf.sv */
`include "adc_acq_params.svh"
`default_nettype none

module adc_to_circ_buf
    import adc_acq_pkg::*;
(
    input  wire                       adc_clk,
    input  wire                       reset,
    input  wire sample_pair_t         pair_dat,             // registered adc pair
    input  wire                       use_dummy_data,       // counter pattern instead of adc
    input  wire                       dummy_dat_reset_mode, // restart counter on each trigger
    input  wire                       cbuf_wr_en,           // from the trigger controller
    input  wire                       trig_pulse,           // accepted trigger, one cycle
    output logic                      wr_valid,
    output logic [`CBUF_ADDR_W-1:0]   wr_addr,
    output sample_pair_t              wr_dat
);

    logic [`SAMPLE_W-1:0] dummy_cnt; // integrity test pattern

    //////////////////////////////
    // dummy data counter
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (reset || (dummy_dat_reset_mode && trig_pulse)) begin
            dummy_cnt <= '0;
        end else if (use_dummy_data && cbuf_wr_en) begin
            dummy_cnt <= dummy_cnt + 1'b1; // wraps at 4095
        end
    end

    //////////////////////////////
    // data source select
    //////////////////////////////

    // counter and its inverse, over-range forced low in dummy mode
    always_ff @(posedge adc_clk) begin
        if (use_dummy_data) begin
            wr_dat.ovr0  <= 1'b0;
            wr_dat.samp0 <= dummy_cnt;
            wr_dat.ovr1  <= 1'b0;
            wr_dat.samp1 <= ~dummy_cnt;
        end else begin
            wr_dat <= pair_dat;
        end
    end

    //////////////////////////////
    // write address
    //////////////////////////////

    // wr_valid trails cbuf_wr_en by one cycle, the address only
    // steps after a write has landed, so the first write is at 0
    always_ff @(posedge adc_clk) begin
        if (reset) begin
            wr_valid <= 1'b0;
            wr_addr  <= '0;
        end else begin
            wr_valid <= cbuf_wr_en;
            if (!cbuf_wr_en) begin
                wr_addr <= '0;                 // parked while disabled
            end else if (wr_valid) begin
                wr_addr <= wr_addr + 1'b1;     // natural wrap at the top
            end
        end
    end

endmodule

`default_nettype wire

/* source/cbuf_readout.sv */
`include "adc_acq_params.svh"
`default_nettype none

module cbuf_readout
    import adc_acq_pkg::*;
(
    input  wire                       adc_clk,
    input  wire                       reset,
    input  wire                       rd_req,   // host side of the four-phase handshake
    input  wire sample_pair_t         rd_q,     // ram read data
    output logic [`CBUF_ADDR_W-1:0]   rd_addr,
    output logic                      rd_ack,
    output sample_pair_t              rd_data,
    output logic                      rd_trig,  // this word is the trigger word
    output logic                      rd_last,  // final word of the acquisition
    acq_status_if.rdout               status
);

    localparam logic [`CBUF_ADDR_W:0] depth = 1 << `CBUF_ADDR_W;

    typedef enum logic [1:0] {
        rs_idle, // no frozen buffer
        rs_wait, // waiting for rd_req
        rs_read, // ram read in flight
        rs_ack   // ack high, waiting for rd_req to drop
    } rd_state_t;

    rd_state_t             rd_state;
    logic [`CBUF_ADDR_W:0] rem;      // words still to hand out, the current one included

    // rd_addr holds still for the whole handshake, so the ram output is stable
    assign rd_data = rd_q;

    //////////////////////////////
    // handshake fsm
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            rd_state           <= rs_idle;
            rd_addr            <= '0;
            rem                <= '0;
            rd_ack             <= 1'b0;
            rd_trig            <= 1'b0;
            rd_last            <= 1'b0;
            status.acq_release <= 1'b0;
        end else begin
            status.acq_release <= 1'b0;           // single-cycle pulse
            case (rd_state)
                rs_idle: begin
                    // skip the release cycle, acq_done is still high then
                    if (status.acq_done && !status.acq_release) begin
                        rd_state <= rs_wait;
                        if (status.wrapped) begin
                            rd_addr <= status.last_addr + 1'b1; // oldest word
                            rem     <= depth;
                        end else begin
                            rd_addr <= '0;
                            rem     <= {1'b0, status.last_addr} + 1'b1;
                        end
                    end
                end
                rs_wait: begin
                    if (rd_req) begin
                        rd_state <= rs_read;
                    end
                end
                rs_read: begin
                    rd_state <= rs_ack;
                    rd_ack   <= 1'b1;
                    rd_trig  <= (rd_addr == status.trig_addr);
                    rd_last  <= (rem == 'd1);
                end
                rs_ack: begin
                    if (!rd_req) begin
                        rd_ack  <= 1'b0;
                        rd_trig <= 1'b0;
                        rd_last <= 1'b0;
                        rd_addr <= rd_addr + 1'b1;    // wraps with the buffer
                        rem     <= rem - 1'b1;
                        if (rem == 'd1) begin
                            rd_state           <= rs_idle;
                            status.acq_release <= 1'b1;
                        end else begin
                            rd_state <= rs_wait;
                        end
                    end
                end
                default: rd_state <= rs_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/circ_buf_ram.sv */
`include "adc_acq_params.svh"
`default_nettype none

module circ_buf_ram
    import adc_acq_pkg::*;
(
    input  wire                       adc_clk,
    input  wire                       wr_valid,
    input  wire [`CBUF_ADDR_W-1:0]    wr_addr,
    input  wire sample_pair_t         wr_dat,
    input  wire [`CBUF_ADDR_W-1:0]    rd_addr,
    output sample_pair_t              rd_q      // one cycle after rd_addr
);

    localparam int depth = 1 << `CBUF_ADDR_W;

    sample_pair_t mem [depth]; // maps onto block ram

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (wr_valid) begin
            mem[wr_addr] <= wr_dat;
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // registered read, no read enable needed since the readout
    // holds the address for the whole handshake
    always_ff @(posedge adc_clk) begin
        rd_q <= mem[rd_addr];
    end

endmodule

`default_nettype wire
